//--- hw/fas_consts.svh
/*
  Global constants of the filter and analysis path:
  filter length, frame length, sample, coefficient,
  accumulator and bin-index widths, coefficient binary point
*/

`ifndef FAS_CONSTS_SVH
`define FAS_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Filter
//////////////////////////////////////////////////////////////////////
`define FAS_FIR_TAPS    32   // Filter length
`define FAS_COEF_W      20   // Coefficient width
`define FAS_ACC_W       41   // Sample + coefficient + log2(taps)
`define FAS_FRAC_SHIFT  16   // Binary point of the coefficients

//////////////////////////////////////////////////////////////////////
// Framing and analysis
//////////////////////////////////////////////////////////////////////
`define FAS_SAMPLE_W    16   // Sample width
`define FAS_FRAME_LEN   16   // Samples per frame
`define FAS_BIN_W       4    // Width of the bin index

`endif

//--- hw/fir_pkg.sv
/*
  Filter types and coefficients:
  coef_t and acc_t, and the constant 32-entry low-pass table
*/

`include "fas_consts.svh"

package fir_pkg;

  typedef logic signed [`FAS_COEF_W-1:0] coef_t;   // Q3.16 coefficient
  typedef logic signed [`FAS_ACC_W-1:0]  acc_t;    // Full-precision tap sum

  // Entry 0 multiplies the newest sample, table is symmetric
  localparam coef_t fir_coefs [0:`FAS_FIR_TAPS-1] = '{
    20'hFFF9E,   // -1.495e-3
    20'hFFF86,
    20'hFFFA7,
    20'h0003B,
    20'h0014B,
    20'h0024A,
    20'h00222,
    20'hFFFE4,
    20'hFFBC5,
    20'hFF7CA,
    20'hFF74E,   // Deepest side lobe
    20'hFFD74,
    20'h00B1A,
    20'h01DAC,
    20'h02F9E,
    20'h03AA9,   // Centre pair, 0.229
    20'h03AA9,
    20'h02F9E,
    20'h01DAC,
    20'h00B1A,
    20'hFFD74,
    20'hFF74E,
    20'hFF7CA,
    20'hFFBC5,
    20'hFFFE4,
    20'h00222,
    20'h0024A,
    20'h0014B,
    20'h0003B,
    20'hFFFA7,
    20'hFFF86,
    20'hFFF9E    // Oldest tap
  };

endpackage

//--- hw/frame_pkg.sv
/*
  Types shared along the sample path:
  sample_t, frame_t and bin_t
*/

`include "fas_consts.svh"

package frame_pkg;

  // Filtered or raw sample, two's complement
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // Sixteen samples, element 0 is the oldest
  typedef sample_t [`FAS_FRAME_LEN-1:0] frame_t;

  // Position of a sample inside a frame
  typedef logic [`FAS_BIN_W-1:0] bin_t;

endpackage

//--- hw/fir_filter.sv
/*
  32-tap streaming low-pass FIR filter
  Delay line, burst fill counter and registered output
*/

`timescale 1ns/10ps
`include "fas_consts.svh"

module fir_filter (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,
  input  frame_pkg::sample_t data,
  output logic              fir_valid,
  output frame_pkg::sample_t fir_d
);

  import fir_pkg::*;
  import frame_pkg::*;

  localparam int FILL_W = $clog2(`FAS_FIR_TAPS) + 1;

  sample_t [`FAS_FIR_TAPS-1:0] taps;   // Index 0 newest
  logic [FILL_W-1:0]           fill_cnt;
  acc_t                        fir_sum;
  sample_t                     fir_next;
  logic                        window_full;

  assign window_full = (fill_cnt == FILL_W'(`FAS_FIR_TAPS));

  //////////////////////////////////////////////////////////////////////
  // Tap sum over the current window
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    fir_sum = '0;
    for (int i = 0; i < `FAS_FIR_TAPS; i++) begin
      fir_sum = fir_sum + acc_t'($signed(taps[i])) * acc_t'(fir_coefs[i]);
    end
  end

  // Floor shift to the sample scale, low bits kept
  assign fir_next = sample_t'(fir_sum >>> `FAS_FRAC_SHIFT);

  // Delay line keeps stale data through a gap
  always_ff @(posedge clk) begin
    if (data_valid) begin
      taps <= {taps[`FAS_FIR_TAPS-2:0], data};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Fill count and output register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt  <= '0;
      fir_valid <= 1'b0;
      fir_d     <= '0;
    end else if (data_valid) begin
      if (!window_full) begin
        fill_cnt <= fill_cnt + 1'b1;   // Saturates at the tap count
      end
      fir_valid <= window_full;
      fir_d     <= fir_next;
    end else begin
      fill_cnt  <= '0;                 // Gap restarts the burst
      fir_valid <= 1'b0;
    end
  end

  a_valid_needs_full: assert property (
    @(posedge clk) disable iff (rst) fir_valid |-> window_full
  ) else $error("fir_valid high with fill count %0d", fill_cnt);

endmodule

//--- hw/frame_collector.sv
/*
  Serial-to-parallel frame collector
  Gathers sixteen consecutive filtered samples into one frame
*/

`timescale 1ns/10ps
`include "fas_consts.svh"

module frame_collector (
  input  logic              clk,
  input  logic              rst,
  input  logic              fir_valid,
  input  frame_pkg::sample_t fir_d,
  output logic              frame_valid,
  output frame_pkg::frame_t  frame
);

  import frame_pkg::*;

  localparam int CNT_W = $clog2(`FAS_FRAME_LEN);

  logic [CNT_W-1:0] wr_idx;       // Next slot to fill
  frame_t           fill_buf;
  frame_t           next_frame;
  logic             last_slot;

  assign last_slot = (wr_idx == CNT_W'(`FAS_FRAME_LEN - 1));

  // Current buffer with the incoming sample in place
  always_comb begin
    next_frame         = fill_buf;
    next_frame[wr_idx] = fir_d;
  end

  //////////////////////////////////////////////////////////////////////
  // Sample buffer and output frame
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (fir_valid) begin
      fill_buf[wr_idx] <= fir_d;
      if (last_slot) begin
        frame <= next_frame;       // Stays stable while the next frame fills
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_idx      <= '0;
      frame_valid <= 1'b0;
    end else if (fir_valid) begin
      wr_idx      <= wr_idx + 1'b1;  // Wraps after the last slot
      frame_valid <= last_slot;
    end else begin
      wr_idx      <= '0;             // Partial frame is dropped
      frame_valid <= 1'b0;
    end
  end

  a_single_pulse: assert property (
    @(posedge clk) disable iff (rst) frame_valid |=> !frame_valid
  ) else $error("frame_valid held for two cycles");

endmodule

//--- hw/peak_analyst.sv
/*
  Frame analyst
  Reports the index of the largest-magnitude sample, lowest index on a tie
*/

`timescale 1ns/10ps
`include "fas_consts.svh"

module peak_analyst (
  input  logic             clk,
  input  logic             rst,
  input  logic             frame_valid,
  input  frame_pkg::frame_t frame,
  output logic             done,
  output frame_pkg::bin_t   freq
);

  import frame_pkg::*;

  logic [`FAS_SAMPLE_W:0] best_mag;   // One bit more than a sample
  bin_t                   best_idx;

  // Absolute value, -32768 maps to 32768
  function automatic logic [`FAS_SAMPLE_W:0] magnitude(input sample_t s);
    logic [`FAS_SAMPLE_W:0] ext;
    ext = {s[`FAS_SAMPLE_W-1], s};
    if (s[`FAS_SAMPLE_W-1]) begin
      return '0 - ext;
    end
    return ext;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Peak search over the frame
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    best_mag = magnitude(frame[0]);
    best_idx = '0;
    for (int i = 1; i < `FAS_FRAME_LEN; i++) begin
      if (magnitude(frame[i]) > best_mag) begin   // Strict, earlier wins ties
        best_mag = magnitude(frame[i]);
        best_idx = bin_t'(i);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      done <= 1'b0;
      freq <= '0;
    end else begin
      done <= frame_valid;
      if (frame_valid) begin
        freq <= best_idx;   // Held until the next frame
      end
    end
  end

  a_done_follows: assert property (
    @(posedge clk) disable iff (rst) frame_valid |=> done
  ) else $error("done missing after frame_valid");

  a_done_source: assert property (
    @(posedge clk) disable iff (rst) done |-> $past(frame_valid)
  ) else $error("done without a preceding frame_valid");

endmodule

//--- hw/fas_top.sv
/*
  Top level of the filter and analysis path
  FIR filter, frame collector and peak analyst in a valid-only stream
*/

`timescale 1ns/10ps
`include "fas_consts.svh"

module fas_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              data_valid,
  input  frame_pkg::sample_t data,
  output logic              fir_valid,
  output frame_pkg::sample_t fir_d,
  output logic              done,
  output frame_pkg::bin_t   freq
);

  import frame_pkg::*;

  logic   frame_valid;
  frame_t frame;         // Collector to analyst

  fir_filter u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d)
  );

  frame_collector u_collect (
    .clk         (clk),
    .rst         (rst),
    .fir_valid   (fir_valid),
    .fir_d       (fir_d),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

  peak_analyst u_peak (
    .clk         (clk),
    .rst         (rst),
    .frame_valid (frame_valid),
    .frame       (frame),
    .done        (done),
    .freq        (freq)
  );

endmodule

//--- verification/fas_tb.sv
/*
  Testbench of the filter and analysis path
  Burst table, reference model of filter, framing and peak search,
  per-cycle checks and a watchdog
*/

`timescale 1ns/10ps
`include "fas_consts.svh"

module fas_tb;

  import frame_pkg::*;

  localparam int TAPS   = `FAS_FIR_TAPS;
  localparam int FLEN   = `FAS_FRAME_LEN;
  localparam int NROWS  = 8;
  localparam int K_IMP  = 0;   // Single sample of amp at position 40
  localparam int K_CNST = 1;   // Constant amp with a one-LSB bump at position 40
  localparam int K_RAND = 2;   // Random in -amp..amp
  localparam int K_RAMP = 3;   // Rising ramp up to amp with the sign flipping every sample

  // Burst table of length, pattern kind, amplitude and idle cycles after the burst
  localparam int row_len  [0:NROWS-1] = '{90, 80, 48, 120, 20, 47, 70, 64};
  localparam int row_kind [0:NROWS-1] = '{0, 1, 1, 2, 2, 3, 3, 0};
  localparam int row_amp  [0:NROWS-1] = '{16384, -32768, 1000, 32767, 5000, 20000, 30000, -20000};
  localparam int row_gap  [0:NROWS-1] = '{5, 4, 3, 2, 1, 6, 3, 3};

  // Low-pass taps in units of 2^-16 with entry 0 on the newest sample
  localparam int coef_tab [0:TAPS-1] = '{
    -98, -122, -89, 59, 331, 586, 546, -28,
    -1083, -2102, -2226, -652, 2842, 7596, 12190, 15017,
    15017, 12190, 7596, 2842, -652, -2226, -2102, -1083,
    -28, 546, 586, 331, 59, -89, -122, -98
  };

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  logic    fir_valid;
  sample_t fir_d;
  logic    done;
  bin_t    freq;

  // Reference model state
  int      hist [0:TAPS-1];   // Index 0 newest
  int      fill;
  logic    win_ready;         // Window of the last sample is complete
  sample_t win_val;
  logic    exp_fv;
  sample_t exp_fd;
  sample_t frame_buf [0:FLEN-1];
  int      wr_idx;
  logic    pend1;             // Done pipeline
  logic    pend2;
  bin_t    pfreq1;
  bin_t    pfreq2;
  bin_t    exp_freq;
  logic    drv_valid;         // Inputs seen by the DUT at the next edge
  sample_t drv_data;
  int      errors;
  int      checks;
  int      frames;
  int      seed;

  fas_top UUT (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_valid  (fir_valid),
    .fir_d      (fir_d),
    .done       (done),
    .freq       (freq)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic bin_t peak_index();
    int   best;
    int   mag;
    bin_t idx;
    best = -1;
    idx  = '0;
    for (int i = 0; i < FLEN; i++) begin
      mag = (frame_buf[i] < 0) ? -int'(frame_buf[i]) : int'(frame_buf[i]);
      if (mag > best) begin   // Strict compare keeps the lowest index
        best = mag;
        idx  = bin_t'(i);
      end
    end
    return idx;
  endfunction

  task automatic check_reset_state();
    checks++;
    if (fir_valid !== 1'b0 || done !== 1'b0 || fir_d !== '0 || freq !== '0) begin
      errors++;
      $display("MISMATCH at %0t: reset state fir_valid %b done %b fir_d %0d freq %0d",
               $time, fir_valid, done, fir_d, freq);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Model update and checks once per cycle after the edge
  //////////////////////////////////////////////////////////////////////
  task automatic model_and_check();
    logic   exp_done;
    bin_t   done_freq;
    longint acc;
    exp_done  = pend2;
    done_freq = pfreq2;
    pend2     = pend1;
    pfreq2    = pfreq1;
    pend1     = 1'b0;
    if (drv_valid) begin
      exp_fv = win_ready;        // Window of the previous sample appears now
      exp_fd = win_val;
      for (int i = TAPS - 1; i > 0; i--) hist[i] = hist[i-1];
      hist[0] = drv_data;
      if (fill < TAPS) fill++;
      win_ready = (fill == TAPS);
      acc = 0;
      for (int i = 0; i < TAPS; i++) acc += longint'(hist[i]) * longint'(coef_tab[i]);
      win_val = sample_t'(acc >>> `FAS_FRAC_SHIFT);   // Floor shift keeping the low 16 bits
    end else begin
      exp_fv    = 1'b0;
      fill      = 0;
      win_ready = 1'b0;
    end
    checks++;
    if (fir_valid !== exp_fv) begin
      errors++;
      $display("MISMATCH at %0t: fir_valid is %b, expected %b", $time, fir_valid, exp_fv);
    end else if (exp_fv && fir_d !== exp_fd) begin
      errors++;
      $display("MISMATCH at %0t: fir_d is %0d, expected %0d", $time, fir_d, exp_fd);
    end
    // Frame collection
    if (exp_fv) begin
      frame_buf[wr_idx] = exp_fd;
      if (wr_idx == FLEN - 1) begin
        pend1  = 1'b1;
        pfreq1 = peak_index();
        wr_idx = 0;
      end else begin
        wr_idx++;
      end
    end else begin
      wr_idx = 0;                // Partial frame is lost
    end
    if (done === 1'b1 && !exp_done) begin
      errors++;
      $display("Unexpected done pulse at %0t with no complete frame behind it", $time);
    end else if (done !== 1'b1 && exp_done) begin
      errors++;
      $display("Missing done pulse at %0t for a complete frame", $time);
    end
    if (exp_done) begin
      exp_freq = done_freq;
      frames++;
    end
    if (freq !== exp_freq) begin
      errors++;
      $display("MISMATCH at %0t: freq is %0d, expected %0d", $time, freq, exp_freq);
    end
  endtask

  task automatic drive_cycle(input logic v, input sample_t d);
    @(posedge clk);
    #1;
    model_and_check();
    data_valid = v;
    data       = d;
    drv_valid  = v;
    drv_data   = d;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    int r;
    int s;
    seed       = 32'h58846005;
    errors     = 0;
    checks     = 0;
    frames     = 0;
    fill       = 0;
    win_ready  = 1'b0;
    win_val    = '0;
    wr_idx     = 0;
    pend1      = 1'b0;
    pend2      = 1'b0;
    pfreq1     = '0;
    pfreq2     = '0;
    exp_freq   = '0;
    rst        = 1'b1;
    data_valid = 1'b0;
    data       = '0;
    drv_valid  = 1'b0;
    drv_data   = '0;
    repeat (10) begin
      @(posedge clk);
      #1;
      check_reset_state();
    end
    rst = 1'b0;
    for (int row = 0; row < NROWS; row++) begin
      for (int i = 0; i < row_len[row]; i++) begin
        case (row_kind[row])
          K_IMP:  s = (i == 40) ? row_amp[row] : 0;
          K_CNST: s = (i == 40) ? row_amp[row] + 1 : row_amp[row];
          K_RAND: begin
            r = $random(seed);
            s = r % (row_amp[row] + 1);
          end
          K_RAMP: begin
            s = i * row_amp[row] / row_len[row];
            if (i % 2 != 0) s = -s;
          end
          default: s = 0;
        endcase
        drive_cycle(1'b1, sample_t'(s));
      end
      repeat (row_gap[row]) drive_cycle(1'b0, '0);
    end
    repeat (4) drive_cycle(1'b0, '0);   // Let the last done drain
    $display("Checks: %0d, frames: %0d, errors: %0d", checks, frames, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin : watchdog
    int total;
    total = 10 + 4 + 200;
    for (int k = 0; k < NROWS; k++) total += row_len[k] + row_gap[k];
    #(total * 20);
    $display("Timeout: the run did not finish within %0d cycles", total);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- sources.f
+incdir+hw
hw/fir_pkg.sv
hw/frame_pkg.sv
hw/fir_filter.sv
hw/frame_collector.sv
hw/peak_analyst.sv
hw/fas_top.sv
verification/fas_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fas_tb \
  -f sources.f -o fas_sim \
  && ./obj_dir/fas_sim | tee /dev/stderr | grep -x "Regression passed" > /dev/null \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
